// ==== sim.f ====
+incdir+include
logic/csr_pkg.sv
logic/csr_access_ctrl.sv
logic/csr_mode_regs.sv
logic/csr_trap_regs.sv
logic/csr_timer.sv
logic/csr_file_top.sv
dv/csr_file_tb.sv

// ==== include/csr_tb_util.svh ====
`ifndef CSR_TB_UTIL_SVH
`define CSR_TB_UTIL_SVH

// fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// reference model, step_model() once per rising edge with the inputs of that cycle
logic [31:0] m_crmd;
logic [31:0] m_prmd;
logic [31:0] m_ectl;
logic [31:0] m_era;
logic [31:0] m_eentry;
logic [31:0] m_save [4];
logic [31:0] m_tid;
logic [31:0] m_tcfg;
logic [31:0] m_tval;
logic [1:0]  m_soft_is;
logic [7:0]  m_hw_is;
logic [5:0]  m_ecode;
logic [8:0]  m_esubcode;
logic        m_timer_en;
logic        m_ti;

function automatic void init_model();
    m_crmd = csr_pkg::CRMD_RESET;
    m_prmd = '0;
    m_ectl = '0;
    m_era = 'x;
    m_eentry = '0;
    for (int i = 0; i < 4; i++) begin
        m_save[i] = 'x;
    end
    m_tid = '0;
    m_tcfg = '0;
    m_tval = '0;
    m_soft_is = '0;
    m_hw_is = '0;
    m_ecode = '0;
    m_esubcode = '0;
    m_timer_en = 1'b0;
    m_ti = 1'b0;
endfunction

function automatic logic [31:0] estat_value();
    return {1'b0, m_esubcode, m_ecode, 3'b0, 1'b0, m_ti, 1'b0, m_hw_is, m_soft_is};
endfunction

function automatic logic int_pending();
    logic [31:0] e;
    e = estat_value();
    return (|(m_ectl[12:0] & e[12:0])) && m_crmd[2];
endfunction

function automatic logic [1:0] forwarded_plv(input logic ex, input logic er);
    return ex ? 2'b0 : (er ? m_prmd[1:0] : m_crmd[1:0]);
endfunction

function automatic logic [31:0] read_csr(input logic [13:0] a);
    case (a)
        csr_pkg::CSR_CRMD:   return m_crmd;
        csr_pkg::CSR_PRMD:   return m_prmd;
        csr_pkg::CSR_ECTL:   return m_ectl;
        csr_pkg::CSR_ESTAT:  return estat_value();
        csr_pkg::CSR_ERA:    return m_era;
        csr_pkg::CSR_EENTRY: return m_eentry;
        csr_pkg::CSR_SAVE0:  return m_save[0];
        csr_pkg::CSR_SAVE1:  return m_save[1];
        csr_pkg::CSR_SAVE2:  return m_save[2];
        csr_pkg::CSR_SAVE3:  return m_save[3];
        csr_pkg::CSR_TID:    return m_tid;
        csr_pkg::CSR_TCFG:   return m_tcfg;
        csr_pkg::CSR_TVAL:   return m_tval;
        default:             return '0;
    endcase
endfunction

function automatic void step_model(input logic we, input logic [13:0] wa,
                                   input logic [31:0] wd, input logic ex, input logic er,
                                   input logic [5:0] ec, input logic [8:0] esc,
                                   input logic [31:0] pc, input logic [7:0] hw);
    logic w;
    w = we && !ex && !er;
    m_hw_is = hw;
    // timer first, so a ticlr in the same cycle wins
    if (m_timer_en && !(w && wa == csr_pkg::CSR_TCFG)) begin
        if (m_tval != '0) begin
            m_tval = m_tval - 1;
        end else begin
            m_ti = 1'b1;
            if (m_tcfg[1]) begin
                m_tval = {m_tcfg[31:2], 2'b0};
            end else begin
                m_timer_en = 1'b0;
                m_tval = '1;
            end
        end
    end
    if (ex) begin
        m_prmd[2:0] = m_crmd[2:0];
        m_crmd[2:0] = 3'b0;
        m_ecode = ec;
        m_esubcode = esc;
        m_era = pc;
    end else if (er) begin
        m_crmd[2:0] = m_prmd[2:0];
    end
    if (w) begin
        case (wa)
            csr_pkg::CSR_CRMD:   m_crmd = {23'b0, wd[8:0]};
            csr_pkg::CSR_PRMD:   m_prmd = {29'b0, wd[2:0]};
            csr_pkg::CSR_ECTL:   m_ectl = {19'b0, wd[12:0]};
            csr_pkg::CSR_ESTAT:  m_soft_is = wd[1:0];
            csr_pkg::CSR_ERA:    m_era = wd;
            csr_pkg::CSR_EENTRY: m_eentry = {wd[31:6], 6'b0};
            csr_pkg::CSR_SAVE0:  m_save[0] = wd;
            csr_pkg::CSR_SAVE1:  m_save[1] = wd;
            csr_pkg::CSR_SAVE2:  m_save[2] = wd;
            csr_pkg::CSR_SAVE3:  m_save[3] = wd;
            csr_pkg::CSR_TID:    m_tid = wd;
            csr_pkg::CSR_TCFG: begin
                m_tcfg = wd;
                m_timer_en = wd[0];
                m_tval = {wd[31:2], 2'b0};
            end
            csr_pkg::CSR_TICLR:  m_ti = m_ti && !wd[0];
            default:             ;
        endcase
    end
endfunction

`endif

// ==== dv/csr_file_tb.sv ====
module csr_file_tb
    import csr_pkg::*;
();

`include "csr_tb_util.svh"

    localparam int RESET_CYCLES = 5;
    localparam int NUM_CSR      = 14;
    localparam int RESET_TEST   = NUM_CSR + 2;
    localparam int WRITE_TEST   = 60;
    localparam int EXCP_ITER    = 8;
    localparam int EXCP_TEST    = EXCP_ITER * 6;
    localparam int ERTN_TEST    = EXCP_ITER * 3;
    localparam int TIMER_ITER   = 4;
    localparam int TIMER_RUN    = 30;
    localparam int TIMER_TEST   = TIMER_ITER * (TIMER_RUN + 1) + 2;
    localparam int INT_TEST     = 40;
    localparam int TOTAL_CYCLES = RESET_CYCLES + RESET_TEST + WRITE_TEST + EXCP_TEST
                                  + ERTN_TEST + TIMER_TEST + INT_TEST;
    localparam int TIMEOUT      = (TOTAL_CYCLES + 100) * 20;

    logic                  clk;
    logic                  rst;
    logic                  csr_we;
    logic [CSR_ADDR_W-1:0] csr_waddr;
    logic [CSR_DATA_W-1:0] csr_wdata;
    logic [CSR_ADDR_W-1:0] csr_raddr;
    logic                  excp;
    logic [ECODE_W-1:0]    ecode;
    logic [ESUBCODE_W-1:0] esubcode;
    logic [CSR_DATA_W-1:0] era_in;
    logic                  ertn;
    logic [HW_INT_W-1:0]   hw_int;
    logic [CSR_DATA_W-1:0] csr_rdata;
    logic                  has_int;
    logic [PLV_W-1:0]      plv;
    logic [CSR_DATA_W-1:0] eentry;
    logic [CSR_DATA_W-1:0] era_out;
    logic [CSR_DATA_W-1:0] tid;

    logic [31:0] lfsr;
    int          errors;
    string       test_name;

    csr_file_top dut0 (
        .clk(clk), .rst(rst),
        .csr_we_i(csr_we), .csr_waddr_i(csr_waddr), .csr_wdata_i(csr_wdata),
        .csr_raddr_i(csr_raddr), .excp_i(excp), .ecode_i(ecode), .esubcode_i(esubcode),
        .era_i(era_in), .ertn_i(ertn), .hw_int_i(hw_int),
        .csr_rdata_o(csr_rdata), .has_int_o(has_int), .plv_o(plv),
        .eentry_o(eentry), .era_o(era_out), .tid_o(tid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [CSR_ADDR_W-1:0] nth_csr(input int n);
        csr_addr_e a;
        a = a.first();
        for (int i = 0; i < n; i++) begin
            a = a.next();
        end
        return a;
    endfunction

    // two in sixteen picks land on a random, mostly unmapped number
    function automatic logic [CSR_ADDR_W-1:0] pick_addr();
        int idx;
        idx = int'(rand_bits(4));
        if (idx >= NUM_CSR) begin
            return CSR_ADDR_W'(rand_bits(CSR_ADDR_W));
        end
        return nth_csr(idx);
    endfunction

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            errors++;
            $display("MISMATCH %s %s expected %08h actual %08h", test_name, what, exp, act);
        end
    endtask

    task automatic check_outputs();
        check_val("csr_rdata_o", read_csr(csr_raddr), csr_rdata);
        check_val("has_int_o", 32'(int_pending()), 32'(has_int));
        check_val("plv_o", 32'(forwarded_plv(excp, ertn)), 32'(plv));
        check_val("era_o", m_era, era_out);
        check_val("eentry_o", m_eentry, eentry);
        check_val("tid_o", m_tid, tid);
        if (csr_raddr == CSR_EENTRY) begin
            check_val("eentry low bits", 32'h0, 32'(csr_rdata[EENTRY_ALIGN-1:0]));
        end
        if (csr_raddr == CSR_TICLR) begin
            check_val("ticlr read", 32'h0, csr_rdata);
        end
    endtask

    // outputs are compared at the falling edge, the model steps at the rising edge
    task automatic apply_cycle();
        @(negedge clk);
        check_outputs();
        @(posedge clk);
        step_model(csr_we, csr_waddr, csr_wdata, excp, ertn, ecode, esubcode, era_in, hw_int);
        #2;
    endtask

    task automatic drive_idle();
        csr_we = 1'b0;
        excp   = 1'b0;
        ertn   = 1'b0;
    endtask

    task automatic drive_write(input logic [CSR_ADDR_W-1:0] a, input logic [31:0] d);
        csr_we    = 1'b1;
        csr_waddr = a;
        csr_wdata = d;
    endtask

    task automatic test_reset();
        test_name = "reset";
        csr_raddr = CSR_CRMD;
        #1;
        check_val("crmd", CRMD_RESET, csr_rdata);
        check_val("has_int_o", 32'h0, 32'(has_int));
        check_val("plv_o", 32'h0, 32'(plv));
        for (int i = 0; i < NUM_CSR; i++) begin
            csr_raddr = nth_csr(i);
            apply_cycle();
        end
        csr_raddr = 14'h3ff;
        apply_cycle();
        csr_raddr = 14'h002;
        apply_cycle();
    endtask

    task automatic test_writes();
        test_name = "write_readback";
        for (int i = 0; i < WRITE_TEST; i++) begin
            csr_raddr = csr_waddr;
            drive_write(pick_addr(), rand_bits(32));
            apply_cycle();
        end
        drive_idle();
    endtask

    task automatic test_exception();
        test_name = "exception";
        for (int i = 0; i < EXCP_ITER; i++) begin
            drive_write(CSR_CRMD, rand_bits(9));
            csr_raddr = CSR_CRMD;
            apply_cycle();
            // the write in the flush cycle must be dropped
            drive_write(pick_addr(), rand_bits(32));
            excp     = 1'b1;
            ecode    = ECODE_W'(rand_bits(ECODE_W));
            esubcode = ESUBCODE_W'(rand_bits(ESUBCODE_W));
            era_in   = rand_bits(32);
            apply_cycle();
            drive_idle();
            csr_raddr = CSR_CRMD;
            apply_cycle();
            csr_raddr = CSR_PRMD;
            apply_cycle();
            csr_raddr = CSR_ESTAT;
            apply_cycle();
            csr_raddr = CSR_ERA;
            apply_cycle();
        end
    endtask

    task automatic test_return();
        test_name = "exception_return";
        for (int i = 0; i < EXCP_ITER; i++) begin
            drive_write(CSR_PRMD, rand_bits(3));
            csr_raddr = CSR_PRMD;
            apply_cycle();
            drive_write(pick_addr(), rand_bits(32));
            ertn = 1'b1;
            csr_raddr = CSR_CRMD;
            apply_cycle();
            drive_idle();
            apply_cycle();
        end
    endtask

    task automatic test_timer();
        logic [31:0] cfg;
        test_name = "timer";
        hw_int = '0;
        for (int i = 0; i < TIMER_ITER; i++) begin
            // small initval, random periodic, enabled
            cfg = '0;
            cfg[TCFG_EN_BIT] = 1'b1;
            cfg[TCFG_PERIODIC_BIT] = 1'(rand_bits(1));
            cfg[TCFG_INITVAL_LSB +: 3] = 3'(rand_bits(3));
            drive_write(CSR_TCFG, cfg);
            apply_cycle();
            for (int c = 0; c < TIMER_RUN; c++) begin
                drive_idle();
                csr_raddr = c[0] ? CSR_ESTAT : CSR_TVAL;
                if (rand_bits(3) == 0) begin
                    drive_write(CSR_TICLR, rand_bits(2));
                end
                apply_cycle();
            end
        end
        drive_write(CSR_TICLR, 32'h1);
        csr_raddr = CSR_ESTAT;
        apply_cycle();
        drive_idle();
        apply_cycle();
    endtask

    task automatic test_interrupts();
        test_name = "interrupt_summary";
        for (int i = 0; i < INT_TEST; i++) begin
            drive_idle();
            hw_int = HW_INT_W'(rand_bits(HW_INT_W));
            csr_raddr = CSR_ESTAT;
            case (rand_bits(2))
                0: drive_write(CSR_ECTL, rand_bits(INT_W));
                1: drive_write(CSR_CRMD, rand_bits(9));
                2: drive_write(CSR_ESTAT, rand_bits(SOFT_INT_W));
                default: ;
            endcase
            apply_cycle();
        end
        drive_idle();
    endtask

    initial begin
        #(TIMEOUT);
        $display("watchdog expired after %0d time units, errors: %0d", TIMEOUT, errors);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        rst       = 1'b1;
        csr_we    = 1'b0;
        csr_waddr = '0;
        csr_wdata = '0;
        csr_raddr = '0;
        excp      = 1'b0;
        ecode     = '0;
        esubcode  = '0;
        era_in    = '0;
        ertn      = 1'b0;
        hw_int    = '0;
        lfsr      = 32'hfbd5_f7dd;
        errors    = 0;
        init_model();
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
        test_reset();
        test_writes();
        test_exception();
        test_return();
        test_timer();
        test_interrupts();
        $display("checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== logic/csr_file_top.sv ====
module csr_file_top
    import csr_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  csr_we_i,
    input  logic [CSR_ADDR_W-1:0] csr_waddr_i,
    input  logic [CSR_DATA_W-1:0] csr_wdata_i,
    input  logic [CSR_ADDR_W-1:0] csr_raddr_i,
    input  logic                  excp_i,
    input  logic [ECODE_W-1:0]    ecode_i,
    input  logic [ESUBCODE_W-1:0] esubcode_i,
    input  logic [CSR_DATA_W-1:0] era_i,
    input  logic                  ertn_i,
    input  logic [HW_INT_W-1:0]   hw_int_i,
    output logic [CSR_DATA_W-1:0] csr_rdata_o,
    output logic                  has_int_o,
    output logic [PLV_W-1:0]      plv_o,
    output logic [CSR_DATA_W-1:0] eentry_o,
    output logic [CSR_DATA_W-1:0] era_o,
    output logic [CSR_DATA_W-1:0] tid_o
);

    logic [CSR_DATA_W-1:0]               crmd;
    logic [CSR_DATA_W-1:0]               prmd;
    logic [CSR_DATA_W-1:0]               ectl;
    logic [CSR_DATA_W-1:0]               estat;
    logic [SAVE_NUM-1:0][CSR_DATA_W-1:0] save;
    logic [CSR_DATA_W-1:0]               tcfg;
    logic [CSR_DATA_W-1:0]               tval;
    logic                                ti;
    logic                                crmd_we;
    logic                                prmd_we;
    logic                                ectl_we;
    logic                                estat_we;
    logic                                era_we;
    logic                                eentry_we;
    logic [SAVE_NUM-1:0]                 save_we;
    logic                                tid_we;
    logic                                tcfg_we;
    logic                                ticlr_we;
    logic [CSR_DATA_W-1:0]               wdata;
    logic                                excp_pulse;
    logic                                ertn_pulse;

    csr_access_ctrl ctrl0 (
        .clk(clk), .rst(rst),
        .csr_we_i(csr_we_i), .csr_waddr_i(csr_waddr_i), .csr_wdata_i(csr_wdata_i),
        .csr_raddr_i(csr_raddr_i), .excp_i(excp_i), .ertn_i(ertn_i),
        .crmd_i(crmd), .prmd_i(prmd), .ectl_i(ectl), .estat_i(estat),
        .era_i(era_o), .eentry_i(eentry_o), .save_i(save),
        .tid_i(tid_o), .tcfg_i(tcfg), .tval_i(tval),
        .crmd_we_o(crmd_we), .prmd_we_o(prmd_we), .ectl_we_o(ectl_we),
        .estat_we_o(estat_we), .era_we_o(era_we), .eentry_we_o(eentry_we),
        .save_we_o(save_we), .tid_we_o(tid_we), .tcfg_we_o(tcfg_we),
        .ticlr_we_o(ticlr_we), .wdata_o(wdata), .excp_o(excp_pulse),
        .ertn_o(ertn_pulse), .csr_rdata_o(csr_rdata_o)
    );

    csr_mode_regs mode0 (
        .clk(clk), .rst(rst),
        .crmd_we_i(crmd_we), .prmd_we_i(prmd_we), .ectl_we_i(ectl_we),
        .estat_we_i(estat_we), .wdata_i(wdata),
        .excp_i(excp_pulse), .ertn_i(ertn_pulse),
        .ecode_i(ecode_i), .esubcode_i(esubcode_i), .hw_int_i(hw_int_i), .ti_i(ti),
        .crmd_o(crmd), .prmd_o(prmd), .ectl_o(ectl), .estat_o(estat),
        .has_int_o(has_int_o), .plv_o(plv_o)
    );

    csr_trap_regs trap0 (
        .clk(clk), .rst(rst),
        .era_we_i(era_we), .eentry_we_i(eentry_we), .save_we_i(save_we),
        .wdata_i(wdata), .excp_i(excp_pulse), .exc_pc_i(era_i),
        .era_o(era_o), .eentry_o(eentry_o), .save_o(save)
    );

    csr_timer timer0 (
        .clk(clk), .rst(rst),
        .tid_we_i(tid_we), .tcfg_we_i(tcfg_we), .ticlr_we_i(ticlr_we), .wdata_i(wdata),
        .tid_o(tid_o), .tcfg_o(tcfg), .tval_o(tval), .ti_o(ti)
    );

endmodule

// ==== logic/csr_timer.sv ====
module csr_timer
    import csr_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  tid_we_i,
    input  logic                  tcfg_we_i,
    input  logic                  ticlr_we_i,
    input  logic [CSR_DATA_W-1:0] wdata_i,
    output logic [CSR_DATA_W-1:0] tid_o,
    output logic [CSR_DATA_W-1:0] tcfg_o,
    output logic [CSR_DATA_W-1:0] tval_o,
    output logic                  ti_o
);

    logic [CSR_DATA_W-1:0] tid_q;
    logic [CSR_DATA_W-1:0] tcfg_q;
    logic [CSR_DATA_W-1:0] tval_q;
    logic                  timer_en;
    logic                  ti_q;
    logic                  expire;

    // initval sits at bit 2, so the field itself is already initval << 2
    assign expire = !tcfg_we_i && timer_en && (tval_q == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            tid_q    <= '0;
            tcfg_q   <= '0;
            tval_q   <= '0;
            timer_en <= 1'b0;
        end else begin
            if (tid_we_i) begin
                tid_q <= wdata_i;
            end
            if (tcfg_we_i) begin
                tcfg_q   <= wdata_i;
                timer_en <= wdata_i[TCFG_EN_BIT];
                tval_q   <= {wdata_i[CSR_DATA_W-1:TCFG_INITVAL_LSB], {TCFG_INITVAL_LSB{1'b0}}};
            end else if (expire) begin
                if (tcfg_q[TCFG_PERIODIC_BIT]) begin
                    tval_q <= {tcfg_q[CSR_DATA_W-1:TCFG_INITVAL_LSB], {TCFG_INITVAL_LSB{1'b0}}};
                end else begin
                    timer_en <= 1'b0;
                    tval_q   <= '1;
                end
            end else if (timer_en) begin
                tval_q <= tval_q - 1'b1;
            end
        end
    end

    // clear wins over a same-cycle expiry
    always_ff @(posedge clk) begin
        if (rst) begin
            ti_q <= 1'b0;
        end else if (ticlr_we_i && wdata_i[TICLR_CLR_BIT]) begin
            ti_q <= 1'b0;
        end else if (expire) begin
            ti_q <= 1'b1;
        end
    end

    assign tid_o  = tid_q;
    assign tcfg_o = tcfg_q;
    assign tval_o = tval_q;
    assign ti_o   = ti_q;

    a_tval_hold: assert property (@(posedge clk) disable iff (rst)
        (!timer_en && !tcfg_we_i) |=> $stable(tval_q));

endmodule

// ==== logic/csr_trap_regs.sv ====
module csr_trap_regs
    import csr_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                era_we_i,
    input  logic                                eentry_we_i,
    input  logic [SAVE_NUM-1:0]                 save_we_i,
    input  logic [CSR_DATA_W-1:0]               wdata_i,
    input  logic                                excp_i,
    input  logic [CSR_DATA_W-1:0]               exc_pc_i,
    output logic [CSR_DATA_W-1:0]               era_o,
    output logic [CSR_DATA_W-1:0]               eentry_o,
    output logic [SAVE_NUM-1:0][CSR_DATA_W-1:0] save_o
);

    logic [CSR_DATA_W-1:0]              era_q;
    logic [CSR_DATA_W-1:EENTRY_ALIGN]   eentry_q;
    logic [SAVE_NUM-1:0][CSR_DATA_W-1:0] save_q;

    always_ff @(posedge clk) begin
        if (excp_i) begin
            era_q <= exc_pc_i;
        end else if (era_we_i) begin
            era_q <= wdata_i;
        end
    end

    // entry vector is 64-byte aligned
    always_ff @(posedge clk) begin
        if (rst) begin
            eentry_q <= '0;
        end else if (eentry_we_i) begin
            eentry_q <= wdata_i[CSR_DATA_W-1:EENTRY_ALIGN];
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < SAVE_NUM; i++) begin
            if (save_we_i[i]) begin
                save_q[i] <= wdata_i;
            end
        end
    end

    assign era_o    = era_q;
    assign eentry_o = {eentry_q, {EENTRY_ALIGN{1'b0}}};
    assign save_o   = save_q;

endmodule

// ==== logic/csr_mode_regs.sv ====
module csr_mode_regs
    import csr_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  crmd_we_i,
    input  logic                  prmd_we_i,
    input  logic                  ectl_we_i,
    input  logic                  estat_we_i,
    input  logic [CSR_DATA_W-1:0] wdata_i,
    input  logic                  excp_i,
    input  logic                  ertn_i,
    input  logic [ECODE_W-1:0]    ecode_i,
    input  logic [ESUBCODE_W-1:0] esubcode_i,
    input  logic [HW_INT_W-1:0]   hw_int_i,
    input  logic                  ti_i,
    output logic [CSR_DATA_W-1:0] crmd_o,
    output logic [CSR_DATA_W-1:0] prmd_o,
    output logic [CSR_DATA_W-1:0] ectl_o,
    output logic [CSR_DATA_W-1:0] estat_o,
    output logic                  has_int_o,
    output logic [PLV_W-1:0]      plv_o
);

    logic [CSR_DATA_W-1:0]   crmd_q;
    logic [PRMD_PIE_BIT:0]   prmd_q;
    logic [INT_W-1:0]        ectl_q;
    logic [SOFT_INT_W-1:0]   soft_is_q;
    logic [HW_INT_W-1:0]     hw_is_q;
    logic [ECODE_W-1:0]      ecode_q;
    logic [ESUBCODE_W-1:0]   esubcode_q;
    logic [INT_W-1:0]        is_vec;

    always_ff @(posedge clk) begin
        if (rst) begin
            crmd_q <= CRMD_RESET;
            prmd_q <= '0;
        end else if (excp_i) begin
            prmd_q[PRMD_PPLV_LSB +: PLV_W] <= crmd_q[CRMD_PLV_LSB +: PLV_W];
            prmd_q[PRMD_PIE_BIT]           <= crmd_q[CRMD_IE_BIT];
            crmd_q[CRMD_PLV_LSB +: PLV_W]  <= '0;
            crmd_q[CRMD_IE_BIT]            <= 1'b0;
        end else if (ertn_i) begin
            crmd_q[CRMD_PLV_LSB +: PLV_W] <= prmd_q[PRMD_PPLV_LSB +: PLV_W];
            crmd_q[CRMD_IE_BIT]           <= prmd_q[PRMD_PIE_BIT];
        end else begin
            if (crmd_we_i) begin
                crmd_q[CRMD_PLV_LSB +: PLV_W]  <= wdata_i[CRMD_PLV_LSB +: PLV_W];
                crmd_q[CRMD_IE_BIT]            <= wdata_i[CRMD_IE_BIT];
                crmd_q[CRMD_DA_BIT]            <= wdata_i[CRMD_DA_BIT];
                crmd_q[CRMD_PG_BIT]            <= wdata_i[CRMD_PG_BIT];
                crmd_q[CRMD_DATF_LSB +: DAT_W] <= wdata_i[CRMD_DATF_LSB +: DAT_W];
                crmd_q[CRMD_DATM_LSB +: DAT_W] <= wdata_i[CRMD_DATM_LSB +: DAT_W];
            end
            if (prmd_we_i) begin
                prmd_q <= wdata_i[PRMD_PIE_BIT:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ectl_q <= '0;
        end else if (ectl_we_i) begin
            ectl_q <= wdata_i[INT_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            soft_is_q  <= '0;
            hw_is_q    <= '0;
            ecode_q    <= '0;
            esubcode_q <= '0;
        end else begin
            hw_is_q <= hw_int_i;
            if (excp_i) begin
                ecode_q    <= ecode_i;
                esubcode_q <= esubcode_i;
            end else if (estat_we_i) begin
                soft_is_q <= wdata_i[SOFT_INT_W-1:0];
            end
        end
    end

    // bit 12 (ipi) stays zero
    always_comb begin
        is_vec = '0;
        is_vec[SOFT_INT_W-1:0] = soft_is_q;
        is_vec[SOFT_INT_W +: HW_INT_W] = hw_is_q;
        is_vec[TI_BIT] = ti_i;
    end

    always_comb begin
        estat_o = '0;
        estat_o[ESTAT_IS_LSB +: INT_W] = is_vec;
        estat_o[ESTAT_ECODE_LSB +: ECODE_W] = ecode_q;
        estat_o[ESTAT_ESUBCODE_LSB +: ESUBCODE_W] = esubcode_q;
    end

    assign crmd_o    = crmd_q;
    assign prmd_o    = CSR_DATA_W'(prmd_q);
    assign ectl_o    = CSR_DATA_W'(ectl_q);
    assign has_int_o = (|(ectl_q & is_vec)) && crmd_q[CRMD_IE_BIT];

    // forwarded so the fetch side sees the new level in the flush cycle
    assign plv_o = excp_i ? '0 :
                   ertn_i ? prmd_q[PRMD_PPLV_LSB +: PLV_W] : crmd_q[CRMD_PLV_LSB +: PLV_W];

    a_excp_plv0: assert property (@(posedge clk) disable iff (rst)
        excp_i |=> crmd_q[CRMD_PLV_LSB +: PLV_W] == '0);

endmodule

// ==== logic/csr_access_ctrl.sv ====
module csr_access_ctrl
    import csr_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                csr_we_i,
    input  logic [CSR_ADDR_W-1:0]               csr_waddr_i,
    input  logic [CSR_DATA_W-1:0]               csr_wdata_i,
    input  logic [CSR_ADDR_W-1:0]               csr_raddr_i,
    input  logic                                excp_i,
    input  logic                                ertn_i,
    input  logic [CSR_DATA_W-1:0]               crmd_i,
    input  logic [CSR_DATA_W-1:0]               prmd_i,
    input  logic [CSR_DATA_W-1:0]               ectl_i,
    input  logic [CSR_DATA_W-1:0]               estat_i,
    input  logic [CSR_DATA_W-1:0]               era_i,
    input  logic [CSR_DATA_W-1:0]               eentry_i,
    input  logic [SAVE_NUM-1:0][CSR_DATA_W-1:0] save_i,
    input  logic [CSR_DATA_W-1:0]               tid_i,
    input  logic [CSR_DATA_W-1:0]               tcfg_i,
    input  logic [CSR_DATA_W-1:0]               tval_i,
    output logic                                crmd_we_o,
    output logic                                prmd_we_o,
    output logic                                ectl_we_o,
    output logic                                estat_we_o,
    output logic                                era_we_o,
    output logic                                eentry_we_o,
    output logic [SAVE_NUM-1:0]                 save_we_o,
    output logic                                tid_we_o,
    output logic                                tcfg_we_o,
    output logic                                ticlr_we_o,
    output logic [CSR_DATA_W-1:0]               wdata_o,
    output logic                                excp_o,
    output logic                                ertn_o,
    output logic [CSR_DATA_W-1:0]               csr_rdata_o
);

    logic wr_en;

    // a flush in the same cycle drops the csr write
    assign wr_en = csr_we_i && !excp_i && !ertn_i;

    assign wdata_o = csr_wdata_i;
    assign excp_o  = excp_i;
    assign ertn_o  = ertn_i;

    always_comb begin
        crmd_we_o   = 1'b0;
        prmd_we_o   = 1'b0;
        ectl_we_o   = 1'b0;
        estat_we_o  = 1'b0;
        era_we_o    = 1'b0;
        eentry_we_o = 1'b0;
        save_we_o   = '0;
        tid_we_o    = 1'b0;
        tcfg_we_o   = 1'b0;
        ticlr_we_o  = 1'b0;
        if (wr_en) begin
            case (csr_addr_e'(csr_waddr_i))
                CSR_CRMD:   crmd_we_o = 1'b1;
                CSR_PRMD:   prmd_we_o = 1'b1;
                CSR_ECTL:   ectl_we_o = 1'b1;
                CSR_ESTAT:  estat_we_o = 1'b1;
                CSR_ERA:    era_we_o = 1'b1;
                CSR_EENTRY: eentry_we_o = 1'b1;
                CSR_SAVE0:  save_we_o[0] = 1'b1;
                CSR_SAVE1:  save_we_o[1] = 1'b1;
                CSR_SAVE2:  save_we_o[2] = 1'b1;
                CSR_SAVE3:  save_we_o[3] = 1'b1;
                CSR_TID:    tid_we_o = 1'b1;
                CSR_TCFG:   tcfg_we_o = 1'b1;
                CSR_TICLR:  ticlr_we_o = 1'b1;
                default:    ;
            endcase
        end
    end

    always_comb begin
        case (csr_addr_e'(csr_raddr_i))
            CSR_CRMD:   csr_rdata_o = crmd_i;
            CSR_PRMD:   csr_rdata_o = prmd_i;
            CSR_ECTL:   csr_rdata_o = ectl_i;
            CSR_ESTAT:  csr_rdata_o = estat_i;
            CSR_ERA:    csr_rdata_o = era_i;
            CSR_EENTRY: csr_rdata_o = eentry_i;
            CSR_SAVE0:  csr_rdata_o = save_i[0];
            CSR_SAVE1:  csr_rdata_o = save_i[1];
            CSR_SAVE2:  csr_rdata_o = save_i[2];
            CSR_SAVE3:  csr_rdata_o = save_i[3];
            CSR_TID:    csr_rdata_o = tid_i;
            CSR_TCFG:   csr_rdata_o = tcfg_i;
            CSR_TVAL:   csr_rdata_o = tval_i;
            // ticlr is write-only
            default:    csr_rdata_o = '0;
        endcase
    end

    a_one_strobe: assert property (@(posedge clk) disable iff (rst)
        $onehot0({crmd_we_o, prmd_we_o, ectl_we_o, estat_we_o, era_we_o, eentry_we_o,
                  save_we_o, tid_we_o, tcfg_we_o, ticlr_we_o}));

    // the pipeline never raises both flushes at once
    a_flush_excl: assert property (@(posedge clk) disable iff (rst) !(excp_i && ertn_i));

endmodule

// ==== logic/csr_pkg.sv ====
package csr_pkg;

    localparam int CSR_ADDR_W = 14;
    localparam int CSR_DATA_W = 32;
    localparam int HW_INT_W   = 8;
    localparam int SOFT_INT_W = 2;
    localparam int INT_W      = 13;
    localparam int ECODE_W    = 6;
    localparam int ESUBCODE_W = 9;
    localparam int PLV_W      = 2;
    localparam int DAT_W      = 2;
    localparam int SAVE_NUM   = 4;

    typedef enum logic [CSR_ADDR_W-1:0] {
        CSR_CRMD   = 14'h000,
        CSR_PRMD   = 14'h001,
        CSR_ECTL   = 14'h004,
        CSR_ESTAT  = 14'h005,
        CSR_ERA    = 14'h006,
        CSR_EENTRY = 14'h00c,
        CSR_SAVE0  = 14'h030,
        CSR_SAVE1  = 14'h031,
        CSR_SAVE2  = 14'h032,
        CSR_SAVE3  = 14'h033,
        CSR_TID    = 14'h040,
        CSR_TCFG   = 14'h041,
        CSR_TVAL   = 14'h042,
        CSR_TICLR  = 14'h044
    } csr_addr_e;

    // crmd
    localparam int CRMD_PLV_LSB  = 0;
    localparam int CRMD_IE_BIT   = 2;
    localparam int CRMD_DA_BIT   = 3;
    localparam int CRMD_PG_BIT   = 4;
    localparam int CRMD_DATF_LSB = 5;
    localparam int CRMD_DATM_LSB = 7;

    // prmd
    localparam int PRMD_PPLV_LSB = 0;
    localparam int PRMD_PIE_BIT  = 2;

    // estat
    localparam int ESTAT_IS_LSB       = 0;
    localparam int ESTAT_ECODE_LSB    = 16;
    localparam int ESTAT_ESUBCODE_LSB = 22;
    localparam int TI_BIT             = 11;

    // timer
    localparam int TCFG_EN_BIT       = 0;
    localparam int TCFG_PERIODIC_BIT = 1;
    localparam int TCFG_INITVAL_LSB  = 2;
    localparam int TICLR_CLR_BIT     = 0;

    localparam int EENTRY_ALIGN = 6;

    // direct address mode out of reset
    localparam logic [CSR_DATA_W-1:0] CRMD_RESET = CSR_DATA_W'(1 << CRMD_DA_BIT);

endpackage
